/* verilog/div_arith_pkg.sv */
package div_arith_pkg;

    // Operand and result width
    localparam int data_width = 32;

    // One quotient bit per stage
    localparam int div_steps = data_width;

    typedef logic [data_width-1:0] word_t;

    // Arithmetic state handed from stage to stage
    typedef struct packed {
        word_t rem;      // Partial remainder
        word_t quo;      // Dividend out the top, quotient in the bottom
        word_t divisor;
    } div_state_t;

    // Bit of quo that moves into the remainder on the next step
    localparam int quo_msb = data_width - 1;

endpackage

/* verilog/div_tag_pkg.sv */
package div_tag_pkg;

    localparam int addr_width = 8;
    localparam int pc_width   = 32;
    localparam int op_width   = 4;

    typedef logic [addr_width-1:0] addr_t;  // Physical register address
    typedef logic [pc_width-1:0]   pc_t;
    typedef logic [op_width-1:0]   div_op_t;

    // Quotient select, all other codes give the remainder
    localparam div_op_t op_divu = div_op_t'(1);

    // Issue tag, returned untouched with the result
    typedef struct packed {
        div_op_t op;
        addr_t   addr;
        pc_t     pc;
    } div_tag_t;

    // Sideband that rides next to the arithmetic state
    typedef struct packed {
        logic     valid;     // Stage holds a real operation
        logic     div_zero;  // Divisor was zero at issue
        div_tag_t tag;
    } div_side_t;

endpackage

/* verilog/div_issue.sv */
`timescale 1ns/100ps

module div_issue
    import div_arith_pkg::*;
    import div_tag_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  word_t      operand_a,
    input  word_t      operand_b,
    input  div_tag_t   tag_in,
    output div_state_t state_out,
    output div_side_t  side_out
);

    logic       divisor_zero;
    div_state_t state_next;
    div_side_t  side_next;

    assign divisor_zero = (operand_b == '0);

    // Initial working state for stage 0
    always_comb begin
        state_next.rem     = '0;
        state_next.quo     = operand_a;  // Dividend shifts out the top
        state_next.divisor = operand_b;
    end

    always_comb begin
        side_next.valid    = start;
        side_next.div_zero = divisor_zero;
        side_next.tag      = tag_in;
    end

    // Data is captured every cycle, only valid has a reset
    always_ff @(posedge clk) begin
        state_out <= state_next;
        side_out  <= side_next;
        if (reset) begin
            side_out.valid <= 1'b0;
        end
    end

endmodule

/* verilog/div_stage.sv */
`timescale 1ns/100ps

module div_stage
    import div_arith_pkg::*;
    import div_tag_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  div_state_t state_in,
    input  div_side_t  side_in,
    output div_state_t state_out,
    output div_side_t  side_out
);

    logic [data_width:0] shifted;  // Remainder with next dividend bit
    logic [data_width:0] diff;
    logic                fits;
    div_state_t          state_next;

    // Bring down the next dividend bit
    assign shifted = {state_in.rem, state_in.quo[quo_msb]};

    // Trial subtract, one bit wider so the borrow shows
    assign diff = shifted - {1'b0, state_in.divisor};
    assign fits = ~diff[data_width];

    always_comb begin
        state_next.divisor = state_in.divisor;
        if (fits) begin
            state_next.rem = diff[data_width-1:0];
            state_next.quo = {state_in.quo[quo_msb-1:0], 1'b1};
        end else begin
            // Restore, keep the shifted remainder
            state_next.rem = shifted[data_width-1:0];
            state_next.quo = {state_in.quo[quo_msb-1:0], 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        state_out <= state_next;
        side_out  <= side_in;
        if (reset) begin
            side_out.valid <= 1'b0;
        end
    end

endmodule

/* verilog/div_result.sv */
`timescale 1ns/100ps

module div_result
    import div_arith_pkg::*;
    import div_tag_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  div_state_t state_in,
    input  div_side_t  side_in,
    output word_t      result,
    output logic       done,
    output logic       divide_zero_exception,
    output div_tag_t   tag_out
);

    word_t result_next;

    // Op code picks quotient or remainder
    assign result_next = (side_in.tag.op == op_divu) ? state_in.quo : state_in.rem;

    always_ff @(posedge clk) begin
        result  <= result_next;
        tag_out <= side_in.tag;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            done                  <= 1'b0;
            divide_zero_exception <= 1'b0;
        end else begin
            done                  <= side_in.valid;
            divide_zero_exception <= side_in.valid & side_in.div_zero;  // Only with done
        end
    end

endmodule

/* verilog/divider.sv */
`timescale 1ns/100ps

module divider
    import div_arith_pkg::*;
    import div_tag_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     start,
    input  word_t    operand_a,
    input  word_t    operand_b,
    input  div_tag_t tag_in,
    output word_t    result,
    output logic     done,
    output logic     divide_zero_exception,
    output div_tag_t tag_out
);

    // Entry k feeds stage k, the last entry feeds the result register
    div_state_t stage_state [0:div_steps];
    div_side_t  stage_side  [0:div_steps];

    div_issue i_div_issue (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .tag_in    (tag_in),
        .state_out (stage_state[0]),
        .side_out  (stage_side[0])
    );

    // One quotient bit per stage
    for (genvar k = 0; k < div_steps; k++) begin : g_stage
        div_stage i_div_stage (
            .clk       (clk),
            .reset     (reset),
            .state_in  (stage_state[k]),
            .side_in   (stage_side[k]),
            .state_out (stage_state[k+1]),
            .side_out  (stage_side[k+1])
        );
    end

    div_result i_div_result (
        .clk                   (clk),
        .reset                 (reset),
        .state_in              (stage_state[div_steps]),
        .side_in               (stage_side[div_steps]),
        .result                (result),
        .done                  (done),
        .divide_zero_exception (divide_zero_exception),
        .tag_out               (tag_out)
    );

endmodule

/* test/divider_properties.sv */
`timescale 1ns/100ps

module divider_properties
    import div_arith_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic start,
    input logic done,
    input logic divide_zero_exception
);

    localparam int latency = div_steps + 2;  // Sampled start to sampled done

    int unsigned failures = 0;

    a_reset_clear: assert property (@(posedge clk) reset |=> !done && !divide_zero_exception)
        else begin
            $error("done or exception set while in reset");
            failures++;
        end

    // Exception only travels with a result
    a_exception_done: assert property (@(posedge clk) divide_zero_exception |-> done)
        else begin
            $error("divide_zero_exception without done");
            failures++;
        end

    a_latency: assert property (@(posedge clk) disable iff (reset) start |-> ##latency done)
        else begin
            $error("done missing %0d cycles after start", latency);
            failures++;
        end

    // Also covers the empty pipeline right after reset
    a_gap: assert property (@(posedge clk) !start |-> ##latency !done)
        else begin
            $error("done without a matching start");
            failures++;
        end

endmodule

bind divider divider_properties i_divider_properties (.*);

/* test/divider_tb.sv */
`timescale 1ns/100ps

module divider_tb
    import div_arith_pkg::*;
    import div_tag_pkg::*;
();

    localparam int clk_period = 100;
    localparam int reset_len  = 8;
    localparam int latency    = div_steps + 2;  // Drive edge to done
    localparam int random_ops = 40;

    typedef struct packed {
        word_t      a;
        word_t      b;
        div_tag_t   tag;
        logic [3:0] gap;  // Idle cycles before this start
    } stim_t;

    typedef struct packed {
        word_t       result;
        logic        div_zero;
        div_tag_t    tag;
        logic [31:0] due;  // Cycle of the expected done
    } expect_t;

    logic     clk;
    logic     reset;
    logic     start;
    word_t    operand_a;
    word_t    operand_b;
    div_tag_t tag_in;
    word_t    result;
    logic     done;
    logic     divide_zero_exception;
    div_tag_t tag_out;

    stim_t       stim_q[$];
    expect_t     expect_q[$];
    logic [31:0] cycle = '0;
    logic        stim_built = 1'b0;
    integer      seed;
    int unsigned test_num = 0;
    int unsigned pass_count = 0;
    int unsigned fail_count = 0;
    int unsigned error_count = 0;

    divider i_divider (
        .clk                   (clk),
        .reset                 (reset),
        .start                 (start),
        .operand_a             (operand_a),
        .operand_b             (operand_b),
        .tag_in                (tag_in),
        .result                (result),
        .done                  (done),
        .divide_zero_exception (divide_zero_exception),
        .tag_out               (tag_out)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // Zero divisor gives all ones or the dividend
    function automatic word_t expected_result(word_t a, word_t b, div_op_t op);
        if (b == '0) begin
            return (op == op_divu) ? '1 : a;
        end
        return (op == op_divu) ? a / b : a % b;
    endfunction

    task automatic add_entry(input word_t a, input word_t b, input div_op_t op,
                             input addr_t addr, input pc_t pc, input logic [3:0] gap);
        stim_t s;
        s.a       = a;
        s.b       = b;
        s.tag.op   = op;
        s.tag.addr = addr;
        s.tag.pc   = pc;
        s.gap     = gap;
        stim_q.push_back(s);
    endtask

    task automatic load_table();
        add_entry(32'd100, 32'd7, op_divu, 8'h01, 32'h0000_1000, 4'd0);
        add_entry(32'd5, 32'd9, op_divu, 8'h02, 32'h0000_1004, 4'd0);  // a < b
        add_entry(32'd12345, 32'd12345, op_divu, 8'h03, 32'h0000_1008, 4'd0);
        add_entry(32'd0, 32'd77, op_divu, 8'h04, 32'h0000_100c, 4'd1);
        add_entry(32'hffff_ffff, 32'd1, op_divu, 8'h05, 32'h0000_1010, 4'd0);
        add_entry(32'hffff_ffff, 32'hffff_ffff, op_divu, 8'h06, 32'h0000_1014, 4'd3);
        add_entry(32'hffff_ffff, 32'd2, 4'h0, 8'h07, 32'h0000_1018, 4'd0);
        add_entry(32'd100, 32'd7, 4'h2, 8'h08, 32'h0000_101c, 4'd0);
        add_entry(32'd5, 32'd9, 4'hf, 8'h09, 32'h0000_1020, 4'd2);
        add_entry(32'h8000_0000, 32'd3, 4'h0, 8'h0a, 32'h0000_1024, 4'd0);
        add_entry(32'hdead_beef, 32'd0, op_divu, 8'h0b, 32'h0000_1028, 4'd0);
        add_entry(32'd1234, 32'd0, 4'h0, 8'h0c, 32'h0000_102c, 4'd1);
        add_entry(32'd0, 32'd0, op_divu, 8'h0d, 32'h0000_1030, 4'd0);
    endtask

    task automatic add_random_entries(input int count);
        word_t   a;
        word_t   b;
        div_op_t op;
        int      shift;
        for (int i = 0; i < count; i++) begin
            a     = $random(seed);
            shift = $unsigned($random(seed)) % data_width;  // Spread divisor sizes
            b     = word_t'($random(seed)) >> shift;
            if (($random(seed) & 15) == 0) begin
                b = '0;
            end
            op = ($random(seed) & 1) ? op_divu : div_op_t'($random(seed));
            add_entry(a, b, op, addr_t'($random(seed)), pc_t'($random(seed)),
                      (($random(seed) & 7) == 0) ? 4'd1 : 4'd0);
        end
    endtask

    task automatic issue(input stim_t s);
        expect_t e;
        repeat (s.gap) begin
            @(posedge clk);
            start <= 1'b0;
        end
        @(posedge clk);
        start     <= 1'b1;
        operand_a <= s.a;
        operand_b <= s.b;
        tag_in    <= s.tag;
        e.result   = expected_result(s.a, s.b, s.tag.op);
        e.div_zero = (s.b == '0);
        e.tag      = s.tag;
        e.due      = cycle + 1 + latency;
        expect_q.push_back(e);
    endtask

    // Scoreboard, sampled away from the rising edge
    always @(negedge clk) begin : check_done
        expect_t e;
        logic    ok;
        if (!reset && done) begin
            if (expect_q.size() == 0) begin
                $display("done raised with no operation outstanding at cycle %0d", cycle);
                error_count++;
            end else begin
                e  = expect_q.pop_front();
                ok = 1'b1;
                test_num++;
                if (result !== e.result) begin
                    $display("FAIL result: got %h, expected %h", result, e.result);
                    ok = 1'b0;
                end
                if (divide_zero_exception !== e.div_zero) begin
                    $display("FAIL divide_zero_exception: got %h, expected %h",
                             divide_zero_exception, e.div_zero);
                    ok = 1'b0;
                end
                if (tag_out !== e.tag) begin
                    $display("FAIL tag_out: got %h, expected %h", tag_out, e.tag);
                    ok = 1'b0;
                end
                if (cycle !== e.due) begin
                    $display("FAIL done cycle: got %h, expected %h", cycle, e.due);
                    ok = 1'b0;
                end
                if (ok) begin
                    pass_count++;
                    $display("test %0d pc %h: ok", test_num, e.tag.pc);
                end else begin
                    fail_count++;
                    $display("test %0d pc %h: failed", test_num, e.tag.pc);
                end
            end
        end
    end

    initial begin : watchdog
        int unsigned limit;
        wait (stim_built);
        limit = (stim_q.size() + latency + reset_len) * 2;
        repeat (limit) @(posedge clk);
        $display("Timeout after %0d cycles, results still missing", limit);
        $display("sim failed");
        $finish;
    end

    initial begin
        reset     = 1'b1;
        start     = 1'b0;
        operand_a = '0;
        operand_b = '0;
        tag_in    = '0;
        seed      = 32'h6e8a;
        load_table();
        add_random_entries(random_ops);
        stim_built = 1'b1;
        repeat (reset_len) @(posedge clk);
        reset <= 1'b0;
        foreach (stim_q[i]) begin
            issue(stim_q[i]);
        end
        @(posedge clk);
        start <= 1'b0;
        while (expect_q.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
        $display("tests: %0d passed, %0d failed, %0d other errors, %0d assertion failures",
                 pass_count, fail_count, error_count, i_divider.i_divider_properties.failures);
        if (fail_count == 0 && error_count == 0 && pass_count == stim_q.size() &&
            i_divider.i_divider_properties.failures == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
verilog/div_arith_pkg.sv
verilog/div_tag_pkg.sv
verilog/div_issue.sv
verilog/div_stage.sv
verilog/div_result.sv
verilog/divider.sv
test/divider_properties.sv
test/divider_tb.sv

/* Bender.yml */
package:
  name: divider

sources:
  - files:
      - verilog/div_arith_pkg.sv
      - verilog/div_tag_pkg.sv
      - verilog/div_issue.sv
      - verilog/div_stage.sv
      - verilog/div_result.sv
      - verilog/divider.sv
  - target: test
    files:
      - test/divider_properties.sv
      - test/divider_tb.sv
